/* Makefile */
TOP = tbRiscvCore

all: run

build:
	verilator --binary --timing -f riscvCore.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing -f riscvCore.f --top-module riscvCore

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* riscvCore.f */
src/rvIsaPkg.sv
src/corePipePkg.sv
src/fetchStage.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/executeStage.sv
src/riscvCore.sv
testbench/tbRiscvCore.sv

/* src/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit
    import rvIsaPkg::*;
(
    input  word_t  opA,
    input  word_t  opB,
    input  aluOp_t aluOp,
    output word_t  result
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = opB[4:0];
    assign lessThan = $signed(opA) < $signed(opB);   // signed compare for slt

    always_comb begin
        case (aluOp)
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluAdd:  result = opA + opB;
            aluSll:  result = opA << shamt;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = word_t'($signed(opA) >>> shamt);
            aluSub:  result = opA - opB;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
            aluXor:  result = opA ^ opB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/corePipePkg.sv */
`default_nettype none

package corePipePkg;

    import rvIsaPkg::*;

    // where an execute operand comes from
    typedef logic [1:0] fwdSel_t;

    localparam fwdSel_t fwdRegFile   = 2'b00;
    localparam fwdSel_t fwdWriteback = 2'b01;
    localparam fwdSel_t fwdMemory    = 2'b10;

    localparam word_t resetPc = 32'h0000_0000;
    localparam word_t pcStep  = 32'd4;

endpackage

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage
    import rvIsaPkg::*;
    import corePipePkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  regAddr_t rd,
    input  word_t    imm,
    input  aluOp_t   aluOp,
    input  logic     useImm,
    input  logic     regWrite,
    input  logic     storeOp,
    input  word_t    rdata1,
    input  word_t    rdata2,
    output logic     dcacheWen,
    output word_t    dcacheAddr,
    output word_t    dcacheWdata,
    output logic     wrEn,
    output regAddr_t wrAddr,
    output word_t    wrData
);

    // decode/execute
    logic     exRegWrite, exStoreOp, exUseImm;
    regAddr_t exRs1, exRs2, exRd;
    word_t    exImm, exRdata1, exRdata2;
    aluOp_t   exAluOp;

    // execute/memory
    logic     memRegWrite, memStoreOp;
    regAddr_t memRd;
    word_t    memResult, memStoreData;

    // memory/writeback
    logic     wbRegWrite;
    regAddr_t wbRd;
    word_t    wbResult;

    fwdSel_t  fwdSelA, fwdSelB;
    word_t    operandA, operandB, storeData, aluResult;

    // memory stage wins over writeback, x0 never forwarded
    function automatic fwdSel_t selectSource(input regAddr_t src, input logic memWr,
                                             input regAddr_t memDst, input logic wbWr,
                                             input regAddr_t wbDst);
        if (src == '0) return fwdRegFile;
        if (memWr && (memDst == src)) return fwdMemory;
        if (wbWr && (wbDst == src)) return fwdWriteback;
        return fwdRegFile;
    endfunction

    function automatic word_t pickOperand(input fwdSel_t sel, input word_t rf,
                                          input word_t memVal, input word_t wbVal);
        case (sel)
            fwdMemory:    return memVal;
            fwdWriteback: return wbVal;
            default:      return rf;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exRegWrite  <= 1'b0;
            exStoreOp   <= 1'b0;
            memRegWrite <= 1'b0;
            memStoreOp  <= 1'b0;
            wbRegWrite  <= 1'b0;
        end else begin
            exRegWrite  <= regWrite;
            exStoreOp   <= storeOp;
            memRegWrite <= exRegWrite;
            memStoreOp  <= exStoreOp;
            wbRegWrite  <= memRegWrite;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        exRs1        <= rs1;
        exRs2        <= rs2;
        exRd         <= rd;
        exImm        <= imm;
        exAluOp      <= aluOp;
        exUseImm     <= useImm;
        exRdata1     <= rdata1;
        exRdata2     <= rdata2;
        memRd        <= exRd;
        memResult    <= aluResult;
        memStoreData <= storeData;
        wbRd         <= memRd;
        wbResult     <= memResult;
    end

    assign fwdSelA = selectSource(exRs1, memRegWrite, memRd, wbRegWrite, wbRd);
    assign fwdSelB = selectSource(exRs2, memRegWrite, memRd, wbRegWrite, wbRd);

    assign operandA  = pickOperand(fwdSelA, exRdata1, memResult, wbResult);
    assign storeData = pickOperand(fwdSelB, exRdata2, memResult, wbResult);
    assign operandB  = exUseImm ? exImm : storeData;

    aluUnit alu (
        .opA    (operandA),
        .opB    (operandB),
        .aluOp  (exAluOp),
        .result (aluResult)
    );

    // store port from the memory stage
    assign dcacheWen   = memStoreOp;
    assign dcacheAddr  = memResult;
    assign dcacheWdata = byteSwap(memStoreData);

    assign wrEn   = wbRegWrite;
    assign wrAddr = wbRd;
    assign wrData = wbResult;

endmodule

`default_nettype wire

/* src/fetchStage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchStage
    import rvIsaPkg::*;
    import corePipePkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  icacheStall,
    input  word_t icacheRdata,
    output word_t icacheAddr,
    output word_t decodeInstr,
    output logic  decodeValid
);

    word_t pc;

    assign icacheAddr = pc;

    // program counter, holds while the cache stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= resetPc;
        end else if (!icacheStall) begin
            pc <= pc + pcStep;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decodeValid <= 1'b0;
        end else begin
            decodeValid <= !icacheStall;   // stalled cycle becomes a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!icacheStall) begin
            decodeInstr <= byteSwap(icacheRdata);
        end
    end

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import rvIsaPkg::*;
(
    input  word_t    decodeInstr,
    input  logic     decodeValid,
    output regAddr_t rs1,
    output regAddr_t rs2,
    output regAddr_t rd,
    output word_t    imm,
    output aluOp_t   aluOp,
    output logic     useImm,
    output logic     regWrite,
    output logic     storeOp
);

    opcode_t opcode;
    funct3_t funct3;
    logic    altBit;
    logic    isRegReg;
    logic    isRegImm;
    logic    isStore;
    logic    funct3Known;
    aluOp_t  aluSel;
    word_t   immI;
    word_t   immS;

    // instruction fields
    assign opcode = decodeInstr[6:0];
    assign funct3 = decodeInstr[14:12];
    assign altBit = decodeInstr[30];         // funct7 bit, sub and sra
    assign rd     = decodeInstr[11:7];
    assign rs1    = decodeInstr[19:15];
    assign rs2    = decodeInstr[24:20];

    // sign-extended immediates
    assign immI = {{20{decodeInstr[31]}}, decodeInstr[31:20]};
    assign immS = {{20{decodeInstr[31]}}, decodeInstr[31:25], decodeInstr[11:7]};

    // instruction class, nothing for a bubble
    assign isRegReg = decodeValid && (opcode == opRegReg);
    assign isRegImm = decodeValid && (opcode == opRegImm);
    assign isStore  = decodeValid && (opcode == opStore) && (funct3 == f3Word);

    always_comb begin
        aluSel      = aluAdd;
        funct3Known = 1'b1;
        case (funct3)
            f3AddSub: aluSel = (isRegReg && altBit) ? aluSub : aluAdd;
            f3Sll:    aluSel = aluSll;
            f3Slt:    aluSel = aluSlt;
            f3Xor:    aluSel = aluXor;
            f3Shr:    aluSel = altBit ? aluSra : aluSrl;
            f3Or:     aluSel = aluOr;
            f3And:    aluSel = aluAnd;
            default: begin
                funct3Known = 1'b0;          // sltu is not supported
            end
        endcase
    end

    assign aluOp    = isStore ? aluAdd : aluSel;   // stores add base and offset
    assign imm      = isStore ? immS : immI;
    assign useImm   = isRegImm || isStore;
    assign regWrite = (isRegReg || isRegImm) && funct3Known;
    assign storeOp  = isStore;

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile
    import rvIsaPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [regCount];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rdata1 = (rs1 == '0) ? '0 :
                    (wrEn && (wrAddr == rs1)) ? wrData : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 :
                    (wrEn && (wrAddr == rs2)) ? wrData : regs[rs2];

endmodule

`default_nettype wire

/* src/riscvCore.sv */
`timescale 1ns/1ns
`default_nettype none

module riscvCore
    import rvIsaPkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  icacheStall,
    input  word_t icacheRdata,
    output word_t icacheAddr,
    output logic  dcacheWen,
    output word_t dcacheAddr,
    output word_t dcacheWdata
);

    word_t    decodeInstr;
    logic     decodeValid;
    regAddr_t rs1, rs2, rd;
    word_t    imm;
    aluOp_t   aluOp;
    logic     useImm, regWrite, storeOp;
    word_t    rdata1, rdata2;
    logic     wrEn;
    regAddr_t wrAddr;
    word_t    wrData;

    fetchStage fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .icacheAddr  (icacheAddr),
        .decodeInstr (decodeInstr),
        .decodeValid (decodeValid)
    );

    instrDecoder decoder (
        .decodeInstr (decodeInstr),
        .decodeValid (decodeValid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .aluOp       (aluOp),
        .useImm      (useImm),
        .regWrite    (regWrite),
        .storeOp     (storeOp)
    );

    // reads in decode alongside the decoder
    regFile regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    executeStage execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .aluOp       (aluOp),
        .useImm      (useImm),
        .regWrite    (regWrite),
        .storeOp     (storeOp),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .dcacheWen   (dcacheWen),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData)
    );

endmodule

`default_nettype wire

/* src/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    localparam int xlen = 32;
    localparam int regCount = 32;

    typedef logic [xlen-1:0] word_t;              // data, address or instruction
    typedef logic [$clog2(regCount)-1:0] regAddr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [3:0] aluOp_t;

    // opcodes of the kept instruction classes
    localparam opcode_t opRegReg = 7'b0110011;
    localparam opcode_t opRegImm = 7'b0010011;
    localparam opcode_t opStore  = 7'b0100011;

    // funct3 codes
    localparam funct3_t f3AddSub = 3'b000;
    localparam funct3_t f3Sll    = 3'b001;
    localparam funct3_t f3Slt    = 3'b010;
    localparam funct3_t f3Xor    = 3'b100;
    localparam funct3_t f3Shr    = 3'b101;        // srl/sra, bit 30 picks
    localparam funct3_t f3Or     = 3'b110;
    localparam funct3_t f3And    = 3'b111;
    localparam funct3_t f3Word   = 3'b010;        // sw width

    // alu operation codes
    localparam aluOp_t aluAnd = 4'b0000;
    localparam aluOp_t aluOr  = 4'b0001;
    localparam aluOp_t aluAdd = 4'b0010;
    localparam aluOp_t aluSll = 4'b0011;
    localparam aluOp_t aluSrl = 4'b0100;
    localparam aluOp_t aluSra = 4'b0101;
    localparam aluOp_t aluSub = 4'b0110;
    localparam aluOp_t aluSlt = 4'b0111;
    localparam aluOp_t aluXor = 4'b1000;

    // cache words travel with the byte order reversed
    function automatic word_t byteSwap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

/* testbench/tbRiscvCore.sv */
`timescale 1ns/1ns
`default_nettype none

module tbRiscvCore
    import rvIsaPkg::*;
();

    localparam int progLen = 200;
    localparam word_t progBytes = progLen * 4;
    localparam int timeoutCycles = 4 * progLen + 50;
    localparam int drainCycles = 8;                 // lets the last instruction retire
    localparam word_t nopWord = 32'h0000_0013;      // addi x0, x0, 0
    localparam logic [31:0] lfsrSeed = 32'h828529fd;
    localparam logic [31:0] lfsrTaps = 32'h80200003;

    // model operation kinds
    localparam int kAdd = 0;
    localparam int kSub = 1;
    localparam int kAnd = 2;
    localparam int kOr  = 3;
    localparam int kXor = 4;
    localparam int kSlt = 5;
    localparam int kSll = 6;
    localparam int kSrl = 7;
    localparam int kSra = 8;

    logic  clk;
    logic  rst_n;
    logic  icacheStall;
    word_t icacheRdata;
    word_t icacheAddr;
    logic  dcacheWen;
    word_t dcacheAddr;
    word_t dcacheWdata;

    logic [31:0] lfsrState;
    word_t       progMem [progLen];
    logic        isStoreInstr [progLen];
    logic        useImmField [progLen];
    int          kindField [progLen];
    regAddr_t    rdField [progLen];
    regAddr_t    rs1Field [progLen];
    regAddr_t    rs2Field [progLen];
    logic [11:0] immField [progLen];
    word_t       expAddrQ [$];
    word_t       expDataQ [$];
    word_t       expPc;
    int          modelStores;
    int          storesSeen;
    int          cycles;
    int          drained;

    riscvCore UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .icacheAddr  (icacheAddr),
        .dcacheWen   (dcacheWen),
        .dcacheAddr  (dcacheAddr),
        .dcacheWdata (dcacheWdata)
    );

    always #2 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ lfsrTaps;
            end
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic word_t reverseBytes(input word_t w);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    function automatic funct3_t funct3Of(input int kind);
        case (kind)
            kSll:       return 3'b001;
            kSlt:       return 3'b010;
            kXor:       return 3'b100;
            kSrl, kSra: return 3'b101;
            kOr:        return 3'b110;
            kAnd:       return 3'b111;
            default:    return 3'b000;  // add and sub
        endcase
    endfunction

    function automatic word_t signExtend(input logic [11:0] imm12);
        return {{20{imm12[11]}}, imm12};
    endfunction

    // what each instruction should compute per the isa
    function automatic word_t modelAlu(input int kind, input word_t a, input word_t b);
        case (kind)
            kSub:    return a - b;
            kAnd:    return a & b;
            kOr:     return a | b;
            kXor:    return a ^ b;
            kSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            kSll:    return a << b[4:0];
            kSrl:    return a >> b[4:0];
            kSra:    return word_t'($signed(a) >>> b[4:0]);
            default: return a + b;
        endcase
    endfunction

    task automatic buildProgram();
        logic [31:0] bits;
        logic [6:0]  funct7;
        for (int i = 0; i < progLen; i++) begin
            isStoreInstr[i] = (i < 4) || (randomBits(7) >= 90);  // opens with plain stores
            rs2Field[i] = regAddr_t'(randomBits(3));
            if (isStoreInstr[i]) begin
                bits = randomBits(10);
                immField[i] = {bits[9:0], 2'b00};                  // word aligned offset
                progMem[i] = {immField[i][11:5], rs2Field[i], 5'd0, f3Word,
                              immField[i][4:0], opStore};
            end else begin
                useImmField[i] = randomBits(1) == 1;
                rdField[i] = regAddr_t'(randomBits(3));
                rs1Field[i] = regAddr_t'(randomBits(3));
                if (!useImmField[i]) begin
                    kindField[i] = int'(randomBits(4) % 9);
                    funct7 = (kindField[i] == kSub || kindField[i] == kSra) ? 7'b0100000 : '0;
                    progMem[i] = {funct7, rs2Field[i], rs1Field[i], funct3Of(kindField[i]),
                                  rdField[i], opRegReg};
                end else begin
                    bits = randomBits(3);
                    kindField[i] = (bits == 0) ? kAdd : int'(bits) + 1;  // no subi
                    if (kindField[i] >= kSll) begin
                        funct7 = (kindField[i] == kSra) ? 7'b0100000 : '0;
                        bits = randomBits(5);
                        immField[i] = {funct7[6:2], funct7[1:0], bits[4:0]};
                    end else begin
                        bits = randomBits(12);
                        immField[i] = bits[11:0];
                    end
                    progMem[i] = {immField[i], rs1Field[i], funct3Of(kindField[i]),
                                  rdField[i], opRegImm};
                end
            end
        end
    endtask

    // in-order reference run filling the store queues
    task automatic runModel();
        word_t regs [8];
        word_t opB;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        modelStores = 0;
        for (int i = 0; i < progLen; i++) begin
            if (isStoreInstr[i]) begin
                expAddrQ.push_back(regs[0] + signExtend(immField[i]));
                expDataQ.push_back(regs[rs2Field[i][2:0]]);
                modelStores++;
            end else begin
                opB = useImmField[i] ? signExtend(immField[i]) : regs[rs2Field[i][2:0]];
                if (rdField[i] != 0) begin
                    regs[rdField[i][2:0]] = modelAlu(kindField[i], regs[rs1Field[i][2:0]], opB);
                end
            end
        end
    endtask

    function automatic word_t fetchWord(input word_t addr);
        if (addr < progBytes) begin
            return reverseBytes(progMem[addr[9:2]]);
        end
        return reverseBytes(nopWord);       // past the program
    endfunction

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s differs from the model", name);
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s differs from the model", name);
        end
    endtask

    task automatic sampleStores();
        word_t addrExp;
        word_t dataExp;
        if (dcacheWen === 1'b1) begin
            if (expAddrQ.size() == 0) begin
                $display("store pulse to %h arrived after all expected stores", dcacheAddr);
                $display("*** TEST FAILED ***");
                $fatal(1, "extra store pulse");
            end else begin
                addrExp = expAddrQ.pop_front();
                dataExp = expDataQ.pop_front();
                checkWord($sformatf("store %0d address", storesSeen), addrExp, dcacheAddr);
                checkWord($sformatf("store %0d data", storesSeen), reverseBytes(dataExp),
                          dcacheWdata);
                storesSeen++;
            end
        end else if (dcacheWen !== 1'b0) begin
            $display("dcacheWen is unknown in cycle %0d", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "unknown store strobe");
        end
    endtask

    task automatic driveInputs();
        icacheStall = randomBits(2) == 0;   // a quarter of the cycles
        icacheRdata = fetchWord(icacheAddr);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        icacheStall = 1'b0;
        icacheRdata = reverseBytes(nopWord);
        lfsrState = lfsrSeed;
        expPc = '0;
        storesSeen = 0;
        cycles = 0;
        drained = 0;
        buildProgram();
        runModel();

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        driveInputs();

        while (drained < drainCycles) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("timeout, the program did not finish within %0d cycles", timeoutCycles);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
            if (!icacheStall) begin
                expPc = expPc + 4;              // pc holds on a stalled edge
            end
            checkWord("fetch address", expPc, icacheAddr);
            sampleStores();
            if (icacheAddr >= progBytes) begin
                drained++;
            end
            driveInputs();
        end

        checkCount("store count", modelStores, storesSeen);
        checkCount("stores left in queue", 0, expAddrQ.size());
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
